/* hdl/dbg_pkg.sv */
package dbg_pkg;

	//////////////////////////////////////////////////////////////////////
	// word and select code sizes
	//////////////////////////////////////////////////////////////////////

	localparam int WORD_W = 32;       // one debug word
	localparam int SEL_W = 7;         // {stage[2:0], item[3:0]}
	localparam int DUMP_COUNT = 22;   // words per dump, one per code below
	localparam int IDX_W = $clog2(DUMP_COUNT);

	// dump order, fetch through write back
	localparam logic [SEL_W-1:0] DUMP_CODES [DUMP_COUNT] = '{
		7'h00, 7'h01,                                     // fetch
		7'h10, 7'h11, 7'h13, 7'h14, 7'h15, 7'h16, 7'h17, 7'h18, // decode
		7'h20, 7'h21, 7'h23, 7'h24, 7'h25,                // execute
		7'h30, 7'h31, 7'h32, 7'h33, 7'h34,                // memory
		7'h40, 7'h41                                      // write back
	};

	//////////////////////////////////////////////////////////////////////
	// buffer
	//////////////////////////////////////////////////////////////////////

	localparam int FIFO_DEPTH = 4;    // less than a dump, so it fills
	localparam int FIFO_AW = 2;

	//////////////////////////////////////////////////////////////////////
	// uart timing, 8N1
	//////////////////////////////////////////////////////////////////////

	localparam int CLKS_PER_BIT = 8;
	localparam int BAUD_W = $clog2(CLKS_PER_BIT);
	localparam int FRAME_BITS = 10;   // start, 8 data, stop
	localparam int BIT_IDX_W = 4;     // counts 0..9
	localparam int BYTES_PER_WORD = 4;
	localparam int BYTE_IDX_W = $clog2(BYTES_PER_WORD);

	// debug word, whole or split into byte lanes
	typedef union packed {
		logic [WORD_W-1:0] raw;
		struct packed {
			logic [7:0] lane3; // sent last
			logic [7:0] lane2;
			logic [7:0] lane1;
			logic [7:0] lane0; // sent first
		} lanes;
	} dbg_word_t;

endpackage

/* hdl/debug_dump.sv */
`timescale 1ns/10ps

module debug_dump (
	input  logic        clk,
	input  logic        rst,
	input  logic        start,
	output logic        busy,
	output logic        tx,

	// pipeline latches, held while halted
	input  logic [31:0] if_pc,
	input  logic [31:0] if_instr,
	input  logic [1:0]  id_wb,
	input  logic [2:0]  id_mem,
	input  logic [3:0]  id_exe,
	input  logic [31:0] id_pc,
	input  logic [31:0] id_reg_a,
	input  logic [31:0] id_reg_b,
	input  logic [31:0] id_imm,
	input  logic [4:0]  id_rs,
	input  logic [4:0]  id_rt,
	input  logic [4:0]  id_rd,
	input  logic        id_pc_write,
	input  logic        id_ifid_write,
	input  logic [1:0]  ex_wb,
	input  logic [2:0]  ex_mem,
	input  logic [31:0] ex_pc_jump,
	input  logic [31:0] ex_alu_result,
	input  logic        ex_alu_zero,
	input  logic [31:0] ex_reg_b,
	input  logic [4:0]  ex_wreg,
	input  logic [1:0]  mem_wb,
	input  logic        mem_pc_sel,
	input  logic [31:0] mem_pc_jump,
	input  logic [31:0] mem_wd,
	input  logic [31:0] mem_alu_result,
	input  logic [4:0]  mem_wreg,
	input  logic        wb_wr,
	input  logic [31:0] wb_wd
);
	import dbg_pkg::*;

	logic [SEL_W-1:0] sel_code;
	dbg_word_t        latched_word;
	dbg_word_t        push_word;
	dbg_word_t        pop_word;
	logic             push, pop, full, empty; // fifo strobes and flags
	logic             dumping;
	logic             sending;
	logic             start_ok;

	assign start_ok = start & ~busy; // restart only once fully drained
	// words still in flight anywhere in the path
	assign busy = dumping | ~empty | sending;

	dump_sequencer dump_sequencer_i (
		.clk(clk), .rst(rst), .start(start_ok), .full(full),
		.latched_word(latched_word), .sel_code(sel_code),
		.push(push), .push_word(push_word), .dumping(dumping)
	);

	latch_select latch_select_i (.*); // pipeline ports match by name

	word_fifo word_fifo_i (
		.clk(clk), .rst(rst), .push(push), .push_word(push_word),
		.pop(pop), .pop_word(pop_word), .full(full), .empty(empty)
	);

	uart_word_tx uart_word_tx_i (
		.clk(clk), .rst(rst), .empty(empty), .pop_word(pop_word),
		.pop(pop), .tx(tx), .sending(sending)
	);

endmodule

/* hdl/dump_sequencer.sv */
`timescale 1ns/10ps

module dump_sequencer (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      start,        // one-cycle pulse
	input  logic                      full,         // fifo back-pressure
	input  dbg_pkg::dbg_word_t        latched_word, // from latch_select
	output logic [dbg_pkg::SEL_W-1:0] sel_code,
	output logic                      push,
	output dbg_pkg::dbg_word_t        push_word,
	output logic                      dumping
);
	import dbg_pkg::*;

	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(DUMP_COUNT - 1);

	logic [IDX_W-1:0] idx;   // position in DUMP_CODES
	logic             phase; // 0 capture, 1 push

	//////////////////////////////////////////////////////////////////////
	// table walk
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			dumping <= 1'b0;
			idx     <= '0;
			phase   <= 1'b0;
		end
		else if (!dumping)
		begin
			if (start)
			begin
				dumping <= 1'b1;
				idx     <= '0; // always from the first code
				phase   <= 1'b0;
			end
		end
		else if (!phase)
		begin
			phase <= 1'b1; // latch_select has the word next cycle
		end
		else if (!full)
		begin
			// push accepted this edge
			phase <= 1'b0;
			if (idx == LAST_IDX)
			begin
				dumping <= 1'b0; // last word is in the fifo
			end
			else
			begin
				idx <= idx + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// outputs
	//////////////////////////////////////////////////////////////////////

	// code held through both phases, so the word keeps its value while full
	assign sel_code = DUMP_CODES[idx];
	assign push = dumping & phase; // held high until full drops
	assign push_word = latched_word;

endmodule

/* hdl/latch_select.sv */
`timescale 1ns/10ps

module latch_select (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [dbg_pkg::SEL_W-1:0] sel_code,

	// fetch
	input  logic [31:0]               if_pc,
	input  logic [31:0]               if_instr,

	// decode
	input  logic [1:0]                id_wb,
	input  logic [2:0]                id_mem,
	input  logic [3:0]                id_exe,
	input  logic [31:0]               id_pc,
	input  logic [31:0]               id_reg_a,
	input  logic [31:0]               id_reg_b,
	input  logic [31:0]               id_imm,
	input  logic [4:0]                id_rs,
	input  logic [4:0]                id_rt,
	input  logic [4:0]                id_rd,
	input  logic                      id_pc_write,
	input  logic                      id_ifid_write,

	// execute
	input  logic [1:0]                ex_wb,
	input  logic [2:0]                ex_mem,
	input  logic [31:0]               ex_pc_jump,
	input  logic [31:0]               ex_alu_result,
	input  logic                      ex_alu_zero,
	input  logic [31:0]               ex_reg_b,
	input  logic [4:0]                ex_wreg,

	// memory
	input  logic [1:0]                mem_wb,
	input  logic                      mem_pc_sel,
	input  logic [31:0]               mem_pc_jump,
	input  logic [31:0]               mem_wd,
	input  logic [31:0]               mem_alu_result,
	input  logic [4:0]                mem_wreg,

	// write back
	input  logic                      wb_wr,
	input  logic [31:0]               wb_wd,

	output dbg_pkg::dbg_word_t        latched_word
);
	import dbg_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// capture register, one clock behind sel_code
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			latched_word.raw <= '0;
		end
		else
		begin
			latched_word.raw <= '0; // unused lanes and unknown codes stay zero
			case (sel_code)
				// fetch stage
				7'h00: latched_word.raw <= if_pc;
				7'h01: latched_word.raw <= if_instr;

				// decode stage
				7'h10:
				begin
					latched_word.lanes.lane2 <= {4'b0, id_exe};
					latched_word.lanes.lane1 <= {5'b0, id_mem};
					latched_word.lanes.lane0 <= {6'b0, id_wb};
				end
				7'h11: latched_word.raw <= id_pc;
				7'h13: latched_word.raw <= id_reg_a;
				7'h14: latched_word.raw <= id_reg_b;
				7'h15: latched_word.raw <= id_imm;   // sign-extended immediate
				7'h16: latched_word.raw <= {27'b0, id_rs};
				7'h17: latched_word.raw <= {27'b0, id_rt};
				7'h18:
				begin
					// hazard unit strobes share the top lane
					latched_word.lanes.lane3 <= {6'b0, id_pc_write, id_ifid_write};
					latched_word.lanes.lane2 <= {3'b0, id_rs};
					latched_word.lanes.lane1 <= {3'b0, id_rt};
					latched_word.lanes.lane0 <= {3'b0, id_rd};
				end

				// execute stage
				7'h20:
				begin
					latched_word.lanes.lane1 <= {5'b0, ex_mem};
					latched_word.lanes.lane0 <= {6'b0, ex_wb};
				end
				7'h21: latched_word.raw <= ex_pc_jump;
				7'h23: latched_word.raw <= ex_alu_result;
				7'h24: latched_word.raw <= ex_reg_b;  // store data
				7'h25:
				begin
					latched_word.lanes.lane1 <= {7'b0, ex_alu_zero};
					latched_word.lanes.lane0 <= {3'b0, ex_wreg};
				end

				// memory stage
				7'h30: latched_word.lanes.lane0 <= {6'b0, mem_wb};
				7'h31: latched_word.raw <= mem_pc_jump;
				7'h32: latched_word.raw <= mem_wd;     // load data
				7'h33: latched_word.raw <= mem_alu_result;
				7'h34:
				begin
					latched_word.lanes.lane1 <= {7'b0, mem_pc_sel}; // branch taken
					latched_word.lanes.lane0 <= {3'b0, mem_wreg};
				end

				// write back stage
				7'h40: latched_word.raw <= wb_wd;
				7'h41: latched_word.lanes.lane0 <= {7'b0, wb_wr};

				default: latched_word.raw <= '0;
			endcase
		end
	end

endmodule

/* hdl/uart_word_tx.sv */
`timescale 1ns/10ps

module uart_word_tx (
	input  logic               clk,
	input  logic               rst,
	input  logic               empty,
	input  dbg_pkg::dbg_word_t pop_word, // fifo head
	output logic               pop,
	output logic               tx,       // idle high
	output logic               sending   // whole word, four frames
);
	import dbg_pkg::*;

	dbg_word_t              word;     // word being sent
	logic [FRAME_BITS-1:0]  frame;    // shifts out lsb first
	logic [BAUD_W-1:0]      baud_cnt; // clocks within a bit
	logic [BIT_IDX_W-1:0]   bit_idx;  // bit within a frame
	logic [BYTE_IDX_W-1:0]  byte_idx; // lane being sent
	logic                   bit_end;

	// stop, data, start
	function automatic logic [FRAME_BITS-1:0] make_frame(input logic [7:0] data);
		make_frame = {1'b1, data, 1'b0};
	endfunction

	// lane after the current one
	function automatic logic [7:0] next_lane(input dbg_word_t w, input logic [BYTE_IDX_W-1:0] idx);
		case (idx)
			2'd0:    next_lane = w.lanes.lane1;
			2'd1:    next_lane = w.lanes.lane2;
			default: next_lane = w.lanes.lane3;
		endcase
	endfunction

	assign pop = ~sending & ~empty; // next word right after last stop bit
	assign bit_end = (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1));

	//////////////////////////////////////////////////////////////////////
	// frame shifter
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			sending  <= 1'b0;
			frame    <= '1; // line idles high
			baud_cnt <= '0;
			bit_idx  <= '0;
			byte_idx <= '0;
		end
		else if (!sending)
		begin
			if (pop)
			begin
				sending  <= 1'b1;
				frame    <= make_frame(pop_word.lanes.lane0);
				baud_cnt <= '0;
				bit_idx  <= '0;
				byte_idx <= '0;
			end
		end
		else if (!bit_end)
		begin
			baud_cnt <= baud_cnt + 1'b1;
		end
		else
		begin
			baud_cnt <= '0;
			if (bit_idx != BIT_IDX_W'(FRAME_BITS - 1))
			begin
				bit_idx <= bit_idx + 1'b1;
				frame   <= {1'b1, frame[FRAME_BITS-1:1]};
			end
			else if (byte_idx != BYTE_IDX_W'(BYTES_PER_WORD - 1))
			begin
				// stop bit done, start next lane back to back
				bit_idx  <= '0;
				byte_idx <= byte_idx + 1'b1;
				frame    <= make_frame(next_lane(word, byte_idx));
			end
			else
			begin
				sending <= 1'b0; // lane3 stop bit done
				frame   <= '1;
			end
		end
	end

	// held word, loaded on pop
	always_ff @(posedge clk)
	begin
		if (pop)
			word <= pop_word;
	end

	assign tx = frame[0]; // straight from a flop

endmodule

/* hdl/word_fifo.sv */
`timescale 1ns/10ps

module word_fifo (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       push,
	input  logic [dbg_pkg::WORD_W-1:0] push_word,
	input  logic                       pop,
	output logic [dbg_pkg::WORD_W-1:0] pop_word, // head, valid when !empty
	output logic                       full,
	output logic                       empty
);
	import dbg_pkg::*;

	logic [WORD_W-1:0]  mem [FIFO_DEPTH]; // word storage
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0]   count;            // 0..FIFO_DEPTH
	logic               do_push;
	logic               do_pop;

	assign do_push = push & ~full;  // push into full is dropped
	assign do_pop  = pop & ~empty;  // pop from empty is dropped

	//////////////////////////////////////////////////////////////////////
	// storage, no fall-through
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (do_push)
		begin
			mem[wr_ptr] <= push_word;
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // wraps at depth
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	assign pop_word = mem[rd_ptr];
	assign full  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
	assign empty = (count == '0);

endmodule

/* run.sh */
#!/bin/bash
# build the testbench with Verilator, run it, then scan the log for the fail line

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --top-module tb_debug_dump -f tb.f -o tb_sim \
	|| { echo "verilator build failed"; exit 1; }

./obj_dir/tb_sim > "$LOG" 2>&1 || echo "simulator returned a failing status" >> "$LOG"
cat "$LOG"

grep -q "=== FAIL ===" "$LOG" && { echo "simulation reported failure"; exit 1; }
grep -q "simulator returned a failing status" "$LOG" && exit 1 || exit 0

/* tb.f */
hdl/dbg_pkg.sv
hdl/latch_select.sv
hdl/dump_sequencer.sv
hdl/word_fifo.sv
hdl/uart_word_tx.sv
hdl/debug_dump.sv
tb/tb_debug_dump.sv

/* tb/tb_debug_dump.sv */
`timescale 1ns/10ps

module tb_debug_dump;
	import dbg_pkg::*;

	localparam int CLK_NS = 20;
	localparam int BIT_NS = CLKS_PER_BIT * CLK_NS;  // one uart bit
	localparam int NUM_DUMPS = 5;
	localparam int FRAMES_PER_DUMP = DUMP_COUNT * 4; // four bytes per word
	localparam int WATCHDOG_NS =
		NUM_DUMPS * FRAMES_PER_DUMP * 10 * CLKS_PER_BIT * CLK_NS * 2;

	// select codes in dump order
	localparam logic [6:0] DUMP_ORDER [DUMP_COUNT] = '{
		7'h00, 7'h01,                                            // fetch
		7'h10, 7'h11, 7'h13, 7'h14, 7'h15, 7'h16, 7'h17, 7'h18,  // decode
		7'h20, 7'h21, 7'h23, 7'h24, 7'h25,                       // execute
		7'h30, 7'h31, 7'h32, 7'h33, 7'h34,                       // memory
		7'h40, 7'h41                                             // write back
	};

	logic        clk = 1'b0;
	logic        rst = 1'b1;   // high from time zero
	logic        start;
	logic        busy;
	logic        tx;

	// pipeline latches, held for a whole dump
	logic [31:0] if_pc, if_instr, id_pc, id_reg_a, id_reg_b, id_imm;
	logic [31:0] ex_pc_jump, ex_alu_result, ex_reg_b;
	logic [31:0] mem_pc_jump, mem_wd, mem_alu_result, wb_wd;
	logic [4:0]  id_rs, id_rt, id_rd, ex_wreg, mem_wreg;
	logic [3:0]  id_exe;
	logic [2:0]  id_mem, ex_mem;
	logic [1:0]  id_wb, ex_wb, mem_wb;
	logic        id_pc_write, id_ifid_write, ex_alu_zero, mem_pc_sel, wb_wr;

	integer      seed = 32'h2deaf01d;
	logic [31:0] exp_words [DUMP_COUNT];  // model words, table order
	int          dump_bytes;      // bytes decoded in this dump
	int          last_stop_ns;    // mid-point of the latest stop bit
	string       test_name;

	debug_dump dut_i (.*);

	always #(CLK_NS / 2) clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped at first error");
	endtask

	// expected word per select code, narrow fields one per byte lane
	function automatic logic [31:0] model_word(input logic [6:0] code);
		case (code)
			7'h00: model_word = if_pc;
			7'h01: model_word = if_instr;
			7'h10: model_word = {8'h00, 8'(id_exe), 8'(id_mem), 8'(id_wb)};
			7'h11: model_word = id_pc;
			7'h13: model_word = id_reg_a;
			7'h14: model_word = id_reg_b;
			7'h15: model_word = id_imm;
			7'h16: model_word = {27'h0, id_rs};
			7'h17: model_word = {27'h0, id_rt};
			7'h18: model_word = {8'({id_pc_write, id_ifid_write}),
				8'(id_rs), 8'(id_rt), 8'(id_rd)};
			7'h20: model_word = {16'h0000, 8'(ex_mem), 8'(ex_wb)};
			7'h21: model_word = ex_pc_jump;
			7'h23: model_word = ex_alu_result;
			7'h24: model_word = ex_reg_b;
			7'h25: model_word = {16'h0000, 8'(ex_alu_zero), 8'(ex_wreg)};
			7'h30: model_word = {24'h000000, 8'(mem_wb)};
			7'h31: model_word = mem_pc_jump;
			7'h32: model_word = mem_wd;
			7'h33: model_word = mem_alu_result;
			7'h34: model_word = {16'h0000, 8'(mem_pc_sel), 8'(mem_wreg)};
			7'h40: model_word = wb_wd;
			7'h41: model_word = {31'h0, wb_wr};
			default: model_word = 32'h0;
		endcase
	endfunction

	// new random latch values, then the expected words
	task automatic load_pipeline();
		if_pc = $random(seed);
		if_instr = $random(seed);
		id_pc = $random(seed);
		id_reg_a = $random(seed);
		id_reg_b = $random(seed);
		id_imm = $random(seed);
		ex_pc_jump = $random(seed);
		ex_alu_result = $random(seed);
		ex_reg_b = $random(seed);
		mem_pc_jump = $random(seed);
		mem_wd = $random(seed);
		mem_alu_result = $random(seed);
		wb_wd = $random(seed);
		id_rs = 5'($random(seed));
		id_rt = 5'($random(seed));
		id_rd = 5'($random(seed));
		ex_wreg = 5'($random(seed));
		mem_wreg = 5'($random(seed));
		id_exe = 4'($random(seed));
		id_mem = 3'($random(seed));
		ex_mem = 3'($random(seed));
		id_wb = 2'($random(seed));
		ex_wb = 2'($random(seed));
		mem_wb = 2'($random(seed));
		id_pc_write = 1'($random(seed));
		id_ifid_write = 1'($random(seed));
		ex_alu_zero = 1'($random(seed));
		mem_pc_sel = 1'($random(seed));
		wb_wr = 1'($random(seed));
		for (int i = 0; i < DUMP_COUNT; i++)
			exp_words[i] = model_word(DUMP_ORDER[i]);
	endtask

	// called 2 ns after an edge, returns 2 ns after the next one
	task automatic pulse_start();
		start = 1'b1;
		@(posedge clk);
		#2;
		start = 1'b0;
	endtask

	task automatic wait_for_busy(input logic level);
		while (busy !== level)
		begin
			@(posedge clk);
			#2;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// uart decoder, mid-bit sampling
	//////////////////////////////////////////////////////////////////////

	initial
	begin : uart_decoder
		logic [7:0]  data;
		logic [31:0] word;
		int          widx;
		@(negedge rst);
		forever
		begin
			@(negedge tx);      // start bit edge
			#(BIT_NS / 2);
			assert (tx === 1'b0)
			else stop_with_error($sformatf("[%s] start bit of byte %0d did not stay low",
				test_name, dump_bytes));
			for (int b = 0; b < 8; b++)
			begin
				#(BIT_NS);
				data[b] = tx;   // lsb first
			end
			#(BIT_NS);
			assert (tx === 1'b1)
			else stop_with_error($sformatf(
				"** Error [%s] framing failure on byte %0d: expected stop 1, actual %b",
				test_name, dump_bytes, tx));
			last_stop_ns = int'($time);
			word[8 * (dump_bytes % 4) +: 8] = data; // lane0 comes first
			dump_bytes++;
			assert (dump_bytes <= FRAMES_PER_DUMP)
			else stop_with_error($sformatf("[%s] more than %0d bytes in one dump",
				test_name, FRAMES_PER_DUMP));
			if (dump_bytes % 4 == 0)
			begin
				widx = dump_bytes / 4 - 1;
				assert (word === exp_words[widx])
				else stop_with_error($sformatf(
					"** Error [%s word %0d code %h] expected %h actual %h",
					test_name, widx, DUMP_ORDER[widx], exp_words[widx], word));
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// watchdog
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the dumps did not finish", WATCHDOG_NS);
		$display("=== FAIL ===");
		$fatal(1, "timeout");
	end

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin : main_flow
		int gap;
		start = 1'b0;
		load_pipeline();    // every input defined before reset ends
		dump_bytes = 0;
		last_stop_ns = 0;
		test_name = "reset idle";
		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;

		// line idle, nothing running
		repeat (10)
		begin
			@(posedge clk);
			#2;
			assert (tx === 1'b1 && busy === 1'b0)
			else stop_with_error($sformatf(
				"** Error [%s] expected tx=1 busy=0, actual tx=%b busy=%b",
				test_name, tx, busy));
		end

		for (int d = 0; d < NUM_DUMPS; d++)
		begin
			test_name = $sformatf("dump %0d", d);
			load_pipeline();
			dump_bytes = 0;
			pulse_start();
			assert (busy === 1'b1)
			else stop_with_error($sformatf("** Error [%s] busy after start expected 1, actual %b",
				test_name, busy));

			// extra start mid-dump, must be ignored
			gap = 20 + int'($unsigned($random(seed)) % 500);
			repeat (gap) @(posedge clk);
			#2;
			assert (busy === 1'b1)
			else stop_with_error($sformatf("[%s] busy dropped before the second start", test_name));
			pulse_start();

			wait_for_busy(1'b0);
			assert (dump_bytes == FRAMES_PER_DUMP)
			else stop_with_error($sformatf("** Error [%s] byte count expected %0d actual %0d",
				test_name, FRAMES_PER_DUMP, dump_bytes));
			assert (int'($time) - last_stop_ns >= BIT_NS / 2)
			else stop_with_error($sformatf("[%s] busy fell before the last stop bit ended", test_name));

			// quiet line until the next start
			repeat (40)
			begin
				@(posedge clk);
				#2;
				assert (tx === 1'b1 && busy === 1'b0)
				else stop_with_error($sformatf(
					"** Error [%s idle] expected tx=1 busy=0, actual tx=%b busy=%b",
					test_name, tx, busy));
			end
		end

		$display("=== PASS ===");
		$finish;
	end

endmodule
